//--- arith/adderUnit.sv
// Execute stage of the FPU
// Aligns and adds the operands, selects sum or product and registers the result
module adderUnit (
	input logic clk,
	input logic rst,
	input logic decodeValid,
	input fpuPkg::decodeBundle decoded,
	output logic execValid,
	output fpuPkg::execBundle exec
);
	import fpuPkg::*;

	// Both candidate results
	execBundle product;
	execBundle sum;

	// Operands ordered by magnitude
	decodedOperand bigOp;
	decodedOperand smallOp;

	// Alignment
	expField expDiff;
	sigWide bigSig;
	sigWide smallSig;
	sigWide shiftedSig;
	logic sticky;
	sigWide alignedSig;

	// Sum and its specials
	sigWide rawSum;
	logic effSub;
	logic anyNan;
	logic opposedInf;

	// Product computed alongside the sum
	multiplierUnit mulPath (
		.decoded(decoded),
		.product(product)
	);

	// ******************************************************************
	// Order by magnitude
	// ******************************************************************
	// Exponent first, significand breaks the tie
	always_comb begin
		if ({decoded.b.exp, decoded.b.sig} > {decoded.a.exp, decoded.a.sig}) begin
			bigOp = decoded.b;
			smallOp = decoded.a;
		end else begin
			bigOp = decoded.a;
			smallOp = decoded.b;
		end
	end

	// ******************************************************************
	// Alignment
	// ******************************************************************
	assign expDiff = bigOp.exp - smallOp.exp;

	// Significands at bits 46..23, 23 bits of guard space below
	assign bigSig = {1'b0, bigOp.sig, 23'b0};
	assign smallSig = {1'b0, smallOp.sig, 23'b0};

	// Gaps of 48 or more shift everything out
	assign shiftedSig = smallSig >> expDiff;

	// Bits lost off the bottom
	assign sticky = |(smallSig & ~({48{1'b1}} << expDiff));

	// Sticky folded into the LSB
	assign alignedSig = {shiftedSig[47:1], shiftedSig[0] | sticky};

	// ******************************************************************
	// Add or subtract
	// ******************************************************************
	// B sign already flipped for subtraction
	assign effSub = bigOp.sign ^ smallOp.sign;

	// Never negative since bigOp has the larger magnitude
	assign rawSum = effSub ? (bigSig - alignedSig) : (bigSig + alignedSig);

	assign anyNan = (decoded.a.cls == clsNan) || (decoded.b.cls == clsNan);

	// Infinity minus infinity
	assign opposedInf = (decoded.a.cls == clsInf) && (decoded.b.cls == clsInf) && effSub;

	always_comb begin
		sum.exp = $signed({2'b00, bigOp.exp});
		sum.sig = rawSum;
		// Exact zero is positive unless both operands are negative
		sum.sign = (rawSum == '0) ? (decoded.a.sign & decoded.b.sign) : bigOp.sign;
		if (anyNan || opposedInf) begin
			sum.flags = flagNan;
		end else if (bigOp.cls == clsInf) begin
			// Infinity always sorts as the larger operand
			sum.flags = bigOp.sign ? flagNegInf : flagPosInf;
		end else begin
			sum.flags = '0;
		end
	end

	// ******************************************************************
	// Execute register
	// ******************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			execValid <= 1'b0;
		end else begin
			execValid <= decodeValid;
		end
	end

	always_ff @(posedge clk) begin
		exec <= (decoded.op == opMul) ? product : sum;
	end

	// Strobe keeps its one-cycle spacing through execute
	assert property (@(posedge clk) disable iff (rst)
		execValid == $past(decodeValid));

endmodule

//--- arith/multiplierUnit.sv
// Combinational product path of the execute stage
// Gives the raw 48-bit significand product, sign, exponent and special flag proposal
module multiplierUnit (
	input fpuPkg::decodeBundle decoded,
	output fpuPkg::execBundle product
);
	import fpuPkg::*;

	// Operands as decoded
	decodedOperand opA;
	decodedOperand opB;

	// Class summary
	logic anyNan;
	logic anyInf;
	logic anyZero;
	logic prodSign;

	// Exponents widened before the sum
	expWide expA;
	expWide expB;

	assign opA = decoded.a;
	assign opB = decoded.b;

	// ******************************************************************
	// Operand classes
	// ******************************************************************
	assign anyNan = (opA.cls == clsNan) || (opB.cls == clsNan);
	assign anyInf = (opA.cls == clsInf) || (opB.cls == clsInf);
	assign anyZero = (opA.cls == clsZero) || (opB.cls == clsZero);

	// Product sign, also the sign of a zero or infinite result
	assign prodSign = opA.sign ^ opB.sign;

	assign expA = $signed({2'b00, opA.exp});
	assign expB = $signed({2'b00, opB.exp});

	// ******************************************************************
	// Product
	// ******************************************************************
	always_comb begin
		product.sign = prodSign;
		// 1.x times 1.y lands at bit 46, or bit 47 when it reaches 2.0
		// A zero operand carries a zero significand, so the product is zero
		product.sig = opA.sig * opB.sig;
		// Bias counted once only
		product.exp = expA + expB - expWide'(expBias);
		// Flag proposal
		if (anyNan || (anyInf && anyZero)) begin
			// Infinity times zero has no value
			product.flags = flagNan;
		end else if (anyInf) begin
			product.flags = prodSign ? flagNegInf : flagPosInf;
		end else begin
			// Zero and overflow decided after rounding
			product.flags = '0;
		end
	end

endmodule

//--- common/fpuPkg.sv
// Shared widths, encodings and stage bundles for the single-precision FPU
// Every stage imports this package, and so does the testbench
package fpuPkg;

	// ******************************************************************
	// Field widths
	// ******************************************************************

	// Packed IEEE single word
	typedef logic [31:0] floatWord;
	// Biased exponent and stored fraction
	typedef logic [7:0] expField;
	typedef logic [22:0] fracField;
	// Significand with hidden bit attached
	typedef logic [23:0] sigField;
	// Raw significand result, 1.0 sits at bit 46 and bit 47 takes the carry
	typedef logic [47:0] sigWide;
	// Signed exponent so overflow and underflow stay visible
	typedef logic signed [9:0] expWide;
	// One-hot special case
	typedef logic [3:0] specialFlags;

	localparam int expBias = 127;
	localparam expField expMax = 8'hFF;

	// Special case encoding, NaN in bit 0 and zero in bit 3
	localparam specialFlags flagNan = 4'b0001;
	localparam specialFlags flagNegInf = 4'b0010;
	localparam specialFlags flagPosInf = 4'b0100;
	localparam specialFlags flagZero = 4'b1000;

	// Default quiet NaN
	localparam floatWord quietNan = 32'h7FC0_0000;

	// ******************************************************************
	// Operations and operand classes
	// ******************************************************************

	typedef enum logic [1:0] {
		opAdd = 2'd0,
		opSub = 2'd1,
		opMul = 2'd2
	} fpuOp;

	typedef enum logic [2:0] {
		clsZero,
		clsNormal,
		clsInf,
		clsNan
	} operandClass;

	// ******************************************************************
	// Stage bundles
	// ******************************************************************

	// One unpacked operand
	typedef struct packed {
		logic sign;
		expField exp;
		sigField sig;
		operandClass cls;
	} decodedOperand;

	// Decode to execute
	typedef struct packed {
		fpuOp op;
		decodedOperand a;
		decodedOperand b;
	} decodeBundle;

	// Execute to result
	typedef struct packed {
		logic sign;
		expWide exp;
		sigWide sig;
		specialFlags flags;
	} execBundle;

endpackage

//--- files.f
+incdir+test
common/fpuPkg.sv
arith/multiplierUnit.sv
arith/adderUnit.sv
verilog/operandClassifier.sv
verilog/resultRounder.sv
verilog/fpuTop.sv
test/tbFpu.sv

//--- test/fpuRefModel.svh
// Reference rules of the FPU for the testbench, included inside the testbench module
// Exact wide arithmetic then one round to nearest even, plus the xorshift generator
`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// Value is mag * 2^expo, result is {flags, word}
function automatic logic [35:0] roundPack(input logic sign, input logic [279:0] mag,
		input int expo);
	int lead;
	int biased;
	logic [24:0] m;
	logic guard;
	logic sticky;
	lead = -1;
	for (int i = 0; i < 280; i++) begin
		if (mag[i]) begin
			lead = i;
		end
	end
	if (lead < 0) begin
		return {flagZero, sign, 31'b0};
	end
	guard = 1'b0;
	sticky = 1'b0;
	if (lead <= 23) begin
		// Fits in 24 bits, exact
		m = 25'(mag << (23 - lead));
	end else begin
		m = 25'(mag >> (lead - 23));
		guard = mag[lead - 24];
		sticky = |(mag & ((280'd1 << (lead - 24)) - 280'd1));
	end
	// Ties go to the even significand
	if (guard && (sticky || m[0])) begin
		m = m + 25'd1;
	end
	biased = expo + lead + 127;
	// Carry into 2.0
	if (m[24]) begin
		m = m >> 1;
		biased++;
	end
	if (biased >= 255) begin
		return {(sign ? flagNegInf : flagPosInf), sign, 8'hFF, 23'b0};
	end
	// Too small for a normal, flushed
	if (biased <= 0) begin
		return {flagZero, sign, 31'b0};
	end
	return {4'b0, sign, biased[7:0], m[22:0]};
endfunction

// Expected {flags, word} for one operation, from the operand bits only
function automatic logic [35:0] expectResult(input fpuOp o, input logic [31:0] a,
		input logic [31:0] b);
	logic signA;
	logic signB;
	logic sign;
	logic [7:0] eA;
	logic [7:0] eB;
	logic [23:0] sA;
	logic [23:0] sB;
	logic nanA;
	logic nanB;
	logic infA;
	logic infB;
	logic zeroA;
	logic zeroB;
	logic [279:0] magA;
	logic [279:0] magB;
	logic [279:0] mag;
	int minE;
	signA = a[31];
	// Subtraction is addition of a negated B
	signB = b[31] ^ (o == opSub);
	eA = a[30:23];
	eB = b[30:23];
	nanA = (eA == 8'hFF) && (a[22:0] != 0);
	nanB = (eB == 8'hFF) && (b[22:0] != 0);
	infA = (eA == 8'hFF) && (a[22:0] == 0);
	infB = (eB == 8'hFF) && (b[22:0] == 0);
	// Subnormals count as zero
	zeroA = (eA == 8'h00);
	zeroB = (eB == 8'h00);
	sA = zeroA ? 24'b0 : {1'b1, a[22:0]};
	sB = zeroB ? 24'b0 : {1'b1, b[22:0]};
	if (o == opMul) begin
		sign = signA ^ signB;
		if (nanA || nanB || ((infA || infB) && (zeroA || zeroB))) begin
			return {flagNan, 32'h7FC0_0000};
		end
		if (infA || infB) begin
			return {(sign ? flagNegInf : flagPosInf), sign, 8'hFF, 23'b0};
		end
		if (zeroA || zeroB) begin
			return {flagZero, sign, 31'b0};
		end
		mag = sA;
		mag = mag * sB;
		return roundPack(sign, mag, int'(eA) + int'(eB) - 300);
	end
	// Add and subtract
	if (nanA || nanB || (infA && infB && (signA != signB))) begin
		return {flagNan, 32'h7FC0_0000};
	end
	if (infA) begin
		return {(signA ? flagNegInf : flagPosInf), signA, 8'hFF, 23'b0};
	end
	if (infB) begin
		return {(signB ? flagNegInf : flagPosInf), signB, 8'hFF, 23'b0};
	end
	if (zeroA && zeroB) begin
		return {flagZero, signA & signB, 31'b0};
	end
	// A zero operand borrows the other exponent, contributes nothing
	if (zeroA) begin
		eA = eB;
	end
	if (zeroB) begin
		eB = eA;
	end
	minE = (eA < eB) ? int'(eA) : int'(eB);
	magA = sA;
	magA = magA << (int'(eA) - minE);
	magB = sB;
	magB = magB << (int'(eB) - minE);
	if (signA == signB) begin
		mag = magA + magB;
		sign = signA;
	end else if (magA >= magB) begin
		mag = magA - magB;
		sign = signA;
	end else begin
		mag = magB - magA;
		sign = signB;
	end
	// Exact cancellation
	if (mag == '0) begin
		return {flagZero, 1'b0, 31'b0};
	end
	return roundPack(sign, mag, minE - 150);
endfunction

`endif

//--- test/tbFpu.sv
// Testbench for the pipelined FPU top level
// Directed tasks plus a random stream, results checked in order from a queue
module tbFpu;
	timeunit 1ns;
	timeprecision 100ps;
	import fpuPkg::*;

	`include "fpuRefModel.svh"

	logic clk;
	logic rst;
	logic start;
	fpuOp op;
	floatWord dataA;
	floatWord dataB;
	logic done;
	floatWord dataR;
	specialFlags casesSpecial;

	// Expected {flags, word}, oldest first
	logic [35:0] expectQ[$];
	int errorCount;
	int checkCount;
	logic [31:0] rngState;

	fpuTop DUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.op(op),
		.dataA(dataA),
		.dataB(dataB),
		.done(done),
		.dataR(dataR),
		.casesSpecial(casesSpecial)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ******************************************************************
	// Scoreboard
	// ******************************************************************
	always @(negedge clk) begin : scoreCheck
		logic [35:0] expected;
		if (done === 1'b1) begin
			if (expectQ.size() == 0) begin
				$display("Result strobe at t=%0t with no operation pending", $time);
				errorCount++;
			end else begin
				expected = expectQ.pop_front();
				checkCount++;
				if (dataR !== expected[31:0]) begin
					$display("[FAIL] t=%0t dataR expected %08h actual %08h",
						$time, expected[31:0], dataR);
					errorCount++;
				end
				if (casesSpecial !== expected[35:32]) begin
					$display("[FAIL] t=%0t casesSpecial expected %04b actual %04b",
						$time, expected[35:32], casesSpecial);
					errorCount++;
				end
			end
		end
	end

	// Idle operands hold a NaN so flags leaking out of an idle slot would show
	task automatic setIdle();
		start = 1'b0;
		op = opMul;
		dataA = 32'h7FC0_0000;
		dataB = 32'h3F80_0000;
	endtask

	task automatic drainQueue(input int limit);
		int waited;
		waited = 0;
		while (expectQ.size() != 0 && waited < limit) begin
			@(posedge clk);
			waited++;
		end
		if (expectQ.size() != 0) begin
			$display("Timed out after %0d cycles with %0d results missing",
				waited, expectQ.size());
			errorCount++;
			expectQ.delete();
		end
	endtask

	// One operation with a hand-derived answer, latency checked too
	task automatic runDirected(input fpuOp o, input floatWord a, input floatWord b,
			input floatWord word, input specialFlags flags);
		int cycles;
		logic [35:0] model;
		model = expectResult(o, a, b);
		if (model !== {flags, word}) begin
			$display("Reference model gives %09h for %08h and %08h, directed value is %09h",
				model, a, b, {flags, word});
			errorCount++;
		end
		@(negedge clk);
		start = 1'b1;
		op = o;
		dataA = a;
		dataB = b;
		expectQ.push_back({flags, word});
		@(negedge clk);
		setIdle();
		cycles = 1;
		while (done !== 1'b1 && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (done !== 1'b1) begin
			$display("Timed out waiting for the result of %08h and %08h", a, b);
			errorCount++;
		end else if (cycles != 3) begin
			$display("[FAIL] t=%0t done latency expected 3 actual %0d", $time, cycles);
			errorCount++;
		end
		drainQueue(10);
	endtask

	// Called at a falling edge
	task automatic issueRandom();
		logic [31:0] a;
		logic [31:0] b;
		fpuOp o;
		rngState = xorshift32(rngState);
		a = rngState;
		rngState = xorshift32(rngState);
		b = rngState;
		rngState = xorshift32(rngState);
		o = fpuOp'(2'(rngState % 3));
		// Close exponents half the time, so sums cancel and round
		if (rngState[8]) begin
			b[30:23] = a[30:23] ^ {6'b0, rngState[5:4]};
		end
		start = 1'b1;
		op = o;
		dataA = a;
		dataB = b;
		expectQ.push_back(expectResult(o, a, b));
	endtask

	// ******************************************************************
	// Directed tests
	// ******************************************************************
	task automatic exactProducts();
		runDirected(opMul, 32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000, 4'h0);
		runDirected(opMul, 32'hC040_0000, 32'h3F00_0000, 32'hBFC0_0000, 4'h0);
	endtask

	task automatic sumsAndDifferences();
		runDirected(opAdd, 32'h3F80_0000, 32'h4000_0000, 32'h4040_0000, 4'h0);
		runDirected(opSub, 32'h4040_0000, 32'h3F80_0000, 32'h4000_0000, 4'h0);
		// Cancellation to positive zero
		runDirected(opSub, 32'h40A0_0000, 32'h40A0_0000, 32'h0000_0000, 4'h8);
		runDirected(opAdd, 32'hC0A0_0000, 32'h40A0_0000, 32'h0000_0000, 4'h8);
		// Wide gaps, small operand ends up in sticky
		runDirected(opAdd, 32'h3F80_0000, 32'h3080_0000, 32'h3F80_0000, 4'h0);
		runDirected(opSub, 32'h3F80_0000, 32'h3080_0000, 32'h3F80_0000, 4'h0);
		runDirected(opAdd, 32'h7180_0000, 32'h3F80_0000, 32'h7180_0000, 4'h0);
	endtask

	task automatic halfwayRounding();
		// Ties to the even neighbour, down then up
		runDirected(opAdd, 32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000, 4'h0);
		runDirected(opAdd, 32'h3F80_0001, 32'h3380_0000, 32'h3F80_0002, 4'h0);
		runDirected(opMul, 32'h3F80_0800, 32'h3F80_0800, 32'h3F80_1000, 4'h0);
		runDirected(opMul, 32'h3F80_0001, 32'h3FC0_0000, 32'h3FC0_0002, 4'h0);
	endtask

	task automatic specialCases();
		runDirected(opAdd, 32'h7FC0_0000, 32'h3F80_0000, 32'h7FC0_0000, 4'h1);
		runDirected(opMul, 32'h7F80_0001, 32'h3F80_0000, 32'h7FC0_0000, 4'h1);
		runDirected(opMul, 32'h7F80_0000, 32'h0000_0000, 32'h7FC0_0000, 4'h1);
		runDirected(opSub, 32'h7F80_0000, 32'h7F80_0000, 32'h7FC0_0000, 4'h1);
		// Signed infinities
		runDirected(opMul, 32'hFF80_0000, 32'h4000_0000, 32'hFF80_0000, 4'h2);
		runDirected(opMul, 32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000, 4'h2);
		runDirected(opMul, 32'h7F80_0000, 32'h4040_0000, 32'h7F80_0000, 4'h4);
		runDirected(opAdd, 32'h7F80_0000, 32'h3F80_0000, 32'h7F80_0000, 4'h4);
		// Overflow
		runDirected(opMul, 32'h7180_0000, 32'h7180_0000, 32'h7F80_0000, 4'h4);
		runDirected(opMul, 32'hF180_0000, 32'h7180_0000, 32'hFF80_0000, 4'h2);
		runDirected(opAdd, 32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F80_0000, 4'h4);
		// Underflow and subnormal inputs
		runDirected(opMul, 32'h0D80_0000, 32'h0D80_0000, 32'h0000_0000, 4'h8);
		runDirected(opMul, 32'h8D80_0000, 32'h0D80_0000, 32'h8000_0000, 4'h8);
		runDirected(opMul, 32'h0000_0001, 32'h4000_0000, 32'h0000_0000, 4'h8);
		runDirected(opMul, 32'h8040_0000, 32'h4000_0000, 32'h8000_0000, 4'h8);
		runDirected(opAdd, 32'h0040_0000, 32'h3F80_0000, 32'h3F80_0000, 4'h0);
		runDirected(opSub, 32'h00C0_0000, 32'h0080_0000, 32'h0000_0000, 4'h8);
		runDirected(opMul, 32'h0000_0000, 32'hC040_0000, 32'h8000_0000, 4'h8);
		runDirected(opAdd, 32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 4'h8);
	endtask

	task automatic streamRandom(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			issueRandom();
		end
		@(negedge clk);
		setIdle();
		drainQueue(20);
	endtask

	task automatic resetMidStream();
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			issueRandom();
		end
		@(negedge clk);
		rst = 1'b1;
		setIdle();
		@(posedge clk);
		// In-flight operations are lost
		expectQ.delete();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			if (done !== 1'b0) begin
				$display("[FAIL] t=%0t done expected 0 actual %b", $time, done);
				errorCount++;
			end
			if (casesSpecial !== 4'b0000) begin
				$display("[FAIL] t=%0t casesSpecial expected 0000 actual %04b",
					$time, casesSpecial);
				errorCount++;
			end
		end
		// Pipe works again
		runDirected(opMul, 32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000, 4'h0);
	endtask

	// ******************************************************************
	// Main sequence
	// ******************************************************************
	initial begin
		errorCount = 0;
		checkCount = 0;
		rngState = 32'hd82f;
		rst = 1'b1;
		setIdle();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		exactProducts();
		sumsAndDifferences();
		halfwayRounding();
		specialCases();
		streamRandom(200);
		resetMidStream();
		$display("Closing report: %0d results checked, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- verilog/fpuTop.sv
// Top level of the pipelined single-precision FPU
// Chains the decode, execute and result stages in order
// Latency is 3 cycles, or 4 when the raw inputs are registered
module fpuTop #(
	parameter int pipeInputs = 0
) (
	input logic clk,
	input logic rst,
	input logic start,
	input fpuPkg::fpuOp op,
	input fpuPkg::floatWord dataA,
	input fpuPkg::floatWord dataB,
	output logic done,
	output fpuPkg::floatWord dataR,
	output fpuPkg::specialFlags casesSpecial
);
	import fpuPkg::*;

	// Decode to execute
	logic decodeValid;
	decodeBundle decoded;

	// Execute to result
	logic execValid;
	execBundle exec;

	// ******************************************************************
	// Stage 1, decode
	// ******************************************************************
	operandClassifier #(
		.pipeInputs(pipeInputs)
	) decodeStage (
		.clk(clk),
		.rst(rst),
		.start(start),
		.op(op),
		.dataA(dataA),
		.dataB(dataB),
		.decodeValid(decodeValid),
		.decoded(decoded)
	);

	// ******************************************************************
	// Stage 2, execute
	// ******************************************************************
	// Sum path here, product path inside
	adderUnit execStage (
		.clk(clk),
		.rst(rst),
		.decodeValid(decodeValid),
		.decoded(decoded),
		.execValid(execValid),
		.exec(exec)
	);

	// ******************************************************************
	// Stage 3, normalize and round
	// ******************************************************************
	resultRounder resultStage (
		.clk(clk),
		.rst(rst),
		.execValid(execValid),
		.exec(exec),
		.done(done),
		.dataR(dataR),
		.casesSpecial(casesSpecial)
	);

endmodule

//--- verilog/operandClassifier.sv
// Decode stage of the FPU
// Splits both operands into fields, classifies them and registers them for execute
module operandClassifier #(
	parameter int pipeInputs = 0
) (
	input logic clk,
	input logic rst,
	input logic start,
	input fpuPkg::fpuOp op,
	input fpuPkg::floatWord dataA,
	input fpuPkg::floatWord dataB,
	output logic decodeValid,
	output fpuPkg::decodeBundle decoded
);
	import fpuPkg::*;

	// Inputs after the optional register
	logic inStart;
	fpuOp inOp;
	floatWord inA;
	floatWord inB;
	decodeBundle nextDecoded;

	// Unpack one word, optionally flipping its sign
	function automatic decodedOperand classify(input floatWord word, input logic flipSign);
		decodedOperand d;
		expField e;
		fracField f;
		e = word[30:23];
		f = word[22:0];
		d.sign = word[31] ^ flipSign;
		d.exp = e;
		// Hidden bit attached by default
		d.sig = {1'b1, f};
		if (e == '0) begin
			// Subnormals flushed along with true zero
			d.cls = clsZero;
			d.exp = '0;
			d.sig = '0;
		end else if (e == expMax) begin
			d.cls = (f != '0) ? clsNan : clsInf;
		end else begin
			d.cls = clsNormal;
		end
		return d;
	endfunction

	// ******************************************************************
	// Optional input register
	// ******************************************************************
	generate
		if (pipeInputs != 0) begin : gInputReg
			always_ff @(posedge clk) begin
				if (rst) begin
					inStart <= 1'b0;
				end else begin
					inStart <= start;
				end
			end
			// Payload follows the strobe
			always_ff @(posedge clk) begin
				inOp <= op;
				inA <= dataA;
				inB <= dataB;
			end
		end else begin : gInputDirect
			assign inStart = start;
			assign inOp = op;
			assign inA = dataA;
			assign inB = dataB;
		end
	endgenerate

	// Subtraction becomes addition of a negated B
	always_comb begin
		nextDecoded.op = inOp;
		nextDecoded.a = classify(inA, 1'b0);
		nextDecoded.b = classify(inB, inOp == opSub);
	end

	// ******************************************************************
	// Decode register
	// ******************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			decodeValid <= 1'b0;
		end else begin
			decodeValid <= inStart;
		end
	end

	always_ff @(posedge clk) begin
		decoded <= nextDecoded;
	end

	// Only the three defined operations enter the pipe
	assert property (@(posedge clk) disable iff (rst)
		start |-> op inside {opAdd, opSub, opMul});

endmodule

//--- verilog/resultRounder.sv
// Result stage of the FPU
// Normalizes, rounds to nearest even, applies special cases and registers the word
module resultRounder (
	input logic clk,
	input logic rst,
	input logic execValid,
	input fpuPkg::execBundle exec,
	output logic done,
	output fpuPkg::floatWord dataR,
	output fpuPkg::specialFlags casesSpecial
);
	import fpuPkg::*;

	// Normalization
	logic [5:0] leadPos;
	logic [5:0] shiftLeft;
	sigWide normSig;
	expWide normExp;

	// Rounding
	logic guardBit;
	logic stickyBit;
	logic roundUp;
	logic [24:0] roundedSig;
	fracField fraction;
	expWide finalExp;

	// Next register contents
	floatWord nextWord;
	specialFlags nextFlags;

	// ******************************************************************
	// Normalize
	// ******************************************************************
	// Highest set bit wins
	always_comb begin
		leadPos = '0;
		for (int i = 0; i < 48; i++) begin
			if (exec.sig[i]) begin
				leadPos = 6'(i);
			end
		end
	end

	// Leading one moved to bit 47
	assign shiftLeft = 6'd47 - leadPos;
	assign normSig = exec.sig << shiftLeft;
	assign normExp = exec.exp + 10'sd1 - $signed({4'b0000, shiftLeft});

	// ******************************************************************
	// Round to nearest even
	// ******************************************************************
	assign guardBit = normSig[23];
	assign stickyBit = |normSig[22:0];
	assign roundUp = guardBit & (stickyBit | normSig[24]);
	assign roundedSig = {1'b0, normSig[47:24]} + 25'(roundUp);

	// Carry out means 10.0, renormalize by one
	assign fraction = roundedSig[24] ? roundedSig[23:1] : roundedSig[22:0];
	assign finalExp = roundedSig[24] ? (normExp + 10'sd1) : normExp;

	// ******************************************************************
	// Special cases, in priority order
	// ******************************************************************
	always_comb begin
		nextWord = {exec.sign, finalExp[7:0], fraction};
		nextFlags = '0;
		if ((exec.flags & flagNan) != '0) begin
			nextWord = quietNan;
			nextFlags = flagNan;
		end else if (((exec.flags & (flagNegInf | flagPosInf)) != '0) ||
				(exec.sig != '0 && finalExp >= 10'sd255)) begin
			// Infinite operand or overflow after rounding
			nextWord = {exec.sign, expMax, 23'b0};
			nextFlags = exec.sign ? flagNegInf : flagPosInf;
		end else if (exec.sig == '0 || finalExp <= 10'sd0) begin
			// Underflow flushed, sign kept
			nextWord = {exec.sign, 31'b0};
			nextFlags = flagZero;
		end
	end

	// ******************************************************************
	// Result register
	// ******************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
			casesSpecial <= '0;
		end else begin
			done <= execValid;
			// Flags only travel with a result
			casesSpecial <= execValid ? nextFlags : '0;
		end
	end

	always_ff @(posedge clk) begin
		dataR <= nextWord;
	end

	// At most one special case per result
	assert property (@(posedge clk) disable iff (rst)
		done |-> $onehot0(casesSpecial));

endmodule
